// File: hdl/dbg_biu_pkg.sv
// Shared definitions for the debug to AHB-Lite bus interface unit
// Holds the bus widths, the AHB encodings, the bus FSM states and the
// request and response structs that pass between the two clock domains
// Modules import it by wildcard in their body and use scoped names in ports

package dbg_biu_pkg;

  ////////////////////////////////////////
  // Widths and endianness
  ////////////////////////////////////////

  // Bus address and data widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // Read lane ordering, big endian is not supported by the bus side
  localparam bit LITTLE_ENDIAN = 1'b1;

  ////////////////////////////////////////
  // Width typedefs
  ////////////////////////////////////////

  // Bus address and data word
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Access size in bytes as the debug transport codes it (1, 2 or 4)
  typedef logic [3:0] word_size_t;

  // AHB size and transfer type codes
  typedef logic [2:0] hsize_t;
  typedef logic [1:0] htrans_t;

  ////////////////////////////////////////
  // AHB encodings
  ////////////////////////////////////////

  // HSIZE
  localparam hsize_t HSIZE_BYTE  = 3'b000;
  localparam hsize_t HSIZE_HWORD = 3'b001;
  localparam hsize_t HSIZE_WORD  = 3'b010;

  // HTRANS, only idle and nonsequential are issued
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;

  // HBURST, single transfers only
  localparam logic [2:0] HBURST_SINGLE = 3'b000;

  // HPROT bits: [0] data, [1] privileged, [2] bufferable, [3] cacheable
  // Debug accesses are privileged data, never buffered or cached
  localparam logic [3:0] HPROT_DBG = 4'b0011;

  ////////////////////////////////////////
  // Bus side FSM
  ////////////////////////////////////////

  // Idle, one address phase cycle, then data phase until HREADY
  typedef enum logic [1:0] {
    XFER_IDLE,
    XFER_ADDR,
    XFER_DATA
  } xfer_state_e;

  ////////////////////////////////////////
  // Cross-domain structs
  ////////////////////////////////////////

  // Latched request, stable from acceptance until ready rises again
  // wdata is already replicated across the byte lanes
  typedef struct packed {
    addr_t  addr;
    data_t  wdata;
    logic   write;
    hsize_t size;
  } dbg_req_t;

  // Response, updated on the transfer acknowledge
  // rdata is aligned and zero-extended
  typedef struct packed {
    data_t rdata;
    logic  err;
  } ahb_rsp_t;

endpackage

// File: hdl/ahb_rdata_align.sv
// Read lane aligner for the bus side
// Picks the addressed byte or halfword out of HRDATA and zero-extends it
// Word reads pass unchanged, purely combinational

module ahb_rdata_align (
  input  dbg_biu_pkg::data_t  HRDATA,
  input  logic [1:0]          addr_lsb,
  input  dbg_biu_pkg::hsize_t size,
  output dbg_biu_pkg::data_t  rdata
);

  import dbg_biu_pkg::*;

  // Lane numbers after endian mapping
  logic [1:0] byte_lane;
  logic       hword_lane;

  ////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////

  // Little endian: offset 0 sits in bits 7:0
  // Big endian mirrors the lane order
  always_comb begin
    if (LITTLE_ENDIAN) begin
      byte_lane  = addr_lsb;
      hword_lane = addr_lsb[1];
    end else begin
      byte_lane  = ~addr_lsb;
      hword_lane = ~addr_lsb[1];
    end
  end

  ////////////////////////////////////////
  // Extraction
  ////////////////////////////////////////

  always_comb begin
    // Upper bits stay zero for narrow reads
    rdata = '0;
    case (size)
      HSIZE_BYTE: begin
        rdata[7:0] = HRDATA[{byte_lane, 3'b000} +: 8];
      end
      HSIZE_HWORD: begin
        rdata[15:0] = HRDATA[{hword_lane, 4'b0000} +: 16];
      end
      default: begin
        rdata = HRDATA;
      end
    endcase
  end

endmodule

// File: hdl/dbg_req_port.sv
// Debug-clock side of the bus interface unit
// Accepts a strobe while biu_rdy is high and latches the request
// Start of a transfer is signalled to the bus side by flipping start_tgl
// Completion comes back as done_tgl and raises biu_rdy again

module dbg_req_port (
  input  logic                    biu_clk,
  input  logic                    ahb_rstn,
  input  dbg_biu_pkg::data_t      biu_di,
  input  dbg_biu_pkg::addr_t      biu_addr,
  input  logic                    biu_strb,
  input  logic                    biu_rw,
  input  dbg_biu_pkg::word_size_t biu_word_size,
  input  logic                    done_tgl,
  output logic                    biu_rdy,
  output dbg_biu_pkg::dbg_req_t   req,
  output logic                    start_tgl
);

  import dbg_biu_pkg::*;

  // Strobe qualified by ready
  logic   strb_acc;
  // Decoded size and lane-replicated write data
  hsize_t size_code;
  data_t  wdata_rep;
  // done_tgl synchronizer and history flop
  logic   done_sync1;
  logic   done_sync2;
  logic   done_sync2_q;
  // Toggle seen on done_tgl
  logic   done_det;

  ////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////

  // Strobes while busy are dropped
  assign strb_acc = biu_strb & biu_rdy;

  // Debug size in bytes to HSIZE code
  always_comb begin
    case (biu_word_size)
      4'd1:    size_code = HSIZE_BYTE;
      4'd2:    size_code = HSIZE_HWORD;
      4'd4:    size_code = HSIZE_WORD;
      // Anything else is treated as a full word
      default: size_code = HSIZE_WORD;
    endcase
  end

  // Write data arrives left-justified
  // Copy the used part into every lane so the slave finds it anywhere
  always_comb begin
    case (size_code)
      HSIZE_BYTE:  wdata_rep = {(DATA_WIDTH/8){biu_di[DATA_WIDTH-1 -: 8]}};
      HSIZE_HWORD: wdata_rep = {(DATA_WIDTH/16){biu_di[DATA_WIDTH-1 -: 16]}};
      default:     wdata_rep = biu_di;
    endcase
  end

  ////////////////////////////////////////
  // Request latch and start toggle
  ////////////////////////////////////////

  // Payload only, held until the next accepted strobe
  // The bus side samples it directly since it is stable while busy
  always_ff @(posedge biu_clk) begin
    if (strb_acc) begin
      req <= '{
        addr:  biu_addr,
        wdata: wdata_rep,
        // biu_rw high means read
        write: ~biu_rw,
        size:  size_code
      };
    end
  end

  // One flip per accepted strobe
  always_ff @(posedge biu_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      start_tgl <= 1'b0;
    end else if (strb_acc) begin
      start_tgl <= ~start_tgl;
    end
  end

  ////////////////////////////////////////
  // Completion and ready
  ////////////////////////////////////////

  // Two flops into biu_clk, third one keeps history for the edge detect
  always_ff @(posedge biu_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      done_sync1   <= 1'b0;
      done_sync2   <= 1'b0;
      done_sync2_q <= 1'b0;
    end else begin
      done_sync1   <= done_tgl;
      done_sync2   <= done_sync1;
      done_sync2_q <= done_sync2;
    end
  end

  assign done_det = done_sync2 ^ done_sync2_q;

  // High out of reset, low from acceptance until the done toggle arrives
  always_ff @(posedge biu_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      biu_rdy <= 1'b1;
    end else if (strb_acc) begin
      biu_rdy <= 1'b0;
    end else if (done_det) begin
      biu_rdy <= 1'b1;
    end
  end

endmodule

// File: hdl/ahb_xfer_ctrl.sv
// AHB-clock side of the bus interface unit
// Picks up the start toggle through a two-flop synchronizer and runs one
// NONSEQ single transfer from the latched request
// On the transfer acknowledge it registers read data and HRESP into rsp
// and flips done_tgl back towards the debug side

module ahb_xfer_ctrl (
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  input  dbg_biu_pkg::dbg_req_t req,
  input  logic                  start_tgl,
  input  dbg_biu_pkg::data_t    HRDATA,
  input  logic                  HREADY,
  input  logic                  HRESP,
  output dbg_biu_pkg::htrans_t  HTRANS,
  output dbg_biu_pkg::ahb_rsp_t rsp,
  output logic                  done_tgl
);

  import dbg_biu_pkg::*;

  // start_tgl synchronizer and history flop
  logic        start_sync1;
  logic        start_sync2;
  logic        start_sync2_q;
  // Toggle seen, and one that is waiting for the FSM
  logic        start_det;
  logic        start_hold;
  logic        start_pend;
  // Bus FSM
  xfer_state_e state;
  // Data phase completed
  logic        xfer_ack;
  // Read data after lane selection
  data_t       rdata_algn;
  // Response registers
  data_t       rdata_q;
  logic        err_q;

  ////////////////////////////////////////
  // Start synchronization
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      start_sync1   <= 1'b0;
      start_sync2   <= 1'b0;
      start_sync2_q <= 1'b0;
    end else begin
      start_sync1   <= start_tgl;
      start_sync2   <= start_sync1;
      start_sync2_q <= start_sync2;
    end
  end

  assign start_det  = start_sync2 ^ start_sync2_q;
  assign start_pend = start_det | start_hold;

  // A start that shows up mid-transfer waits here
  // It is consumed once the FSM is back in idle
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      start_hold <= 1'b0;
    end else begin
      start_hold <= start_pend & (state != XFER_IDLE);
    end
  end

  ////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////

  // Acknowledge is HREADY high in the data phase
  assign xfer_ack = HREADY & (state == XFER_DATA);

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      state  <= XFER_IDLE;
      HTRANS <= HTRANS_IDLE;
    end else begin
      case (state)
        XFER_IDLE: begin
          if (start_pend) begin
            // Address phase on the next cycle
            state  <= XFER_ADDR;
            HTRANS <= HTRANS_NONSEQ;
          end
        end
        XFER_ADDR: begin
          // NONSEQ for exactly one cycle
          state  <= XFER_DATA;
          HTRANS <= HTRANS_IDLE;
        end
        XFER_DATA: begin
          // Wait states keep us here
          if (HREADY) begin
            state <= XFER_IDLE;
          end
        end
        default: begin
          state  <= XFER_IDLE;
          HTRANS <= HTRANS_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Response capture
  ////////////////////////////////////////

  // Byte or halfword lane from the addressed offset
  ahb_rdata_align i_rdata_align (
    .HRDATA   (HRDATA),
    .addr_lsb (req.addr[1:0]),
    .size     (req.size),
    .rdata    (rdata_algn)
  );

  // Read data, payload only
  always_ff @(posedge HCLK) begin
    if (xfer_ack) begin
      rdata_q <= rdata_algn;
    end
  end

  // Error flag and done toggle, both change on the acknowledge edge
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      err_q    <= 1'b0;
      done_tgl <= 1'b0;
    end else if (xfer_ack) begin
      err_q    <= HRESP;
      done_tgl <= ~done_tgl;
    end
  end

  assign rsp = '{rdata: rdata_q, err: err_q};

endmodule

// File: hdl/dbg_ahb_biu.sv
// Debug bus interface unit, top level
// Single memory accesses from the debug transport (biu_clk) go out as
// AHB-Lite single transfers (HCLK), one access in flight at a time
// biu_rdy rising marks the end of an access, biu_do and biu_err are valid then

module dbg_ahb_biu (
  // Debug side
  input  logic                    biu_clk,
  input  dbg_biu_pkg::data_t      biu_di,
  output dbg_biu_pkg::data_t      biu_do,
  input  dbg_biu_pkg::addr_t      biu_addr,
  input  logic                    biu_strb,
  input  logic                    biu_rw,
  output logic                    biu_rdy,
  output logic                    biu_err,
  input  dbg_biu_pkg::word_size_t biu_word_size,
  // Clock and reset, reset serves both domains
  input  logic                    HCLK,
  input  logic                    ahb_rstn,
  // AHB-Lite master
  output logic                    HSEL,
  output dbg_biu_pkg::addr_t      HADDR,
  output dbg_biu_pkg::data_t      HWDATA,
  input  dbg_biu_pkg::data_t      HRDATA,
  output logic                    HWRITE,
  output dbg_biu_pkg::hsize_t     HSIZE,
  output logic [2:0]              HBURST,
  output logic [3:0]              HPROT,
  output dbg_biu_pkg::htrans_t    HTRANS,
  output logic                    HMASTLOCK,
  input  logic                    HREADY,
  input  logic                    HRESP
);

  import dbg_biu_pkg::*;

  // Request and response between the domains
  dbg_req_t req;
  ahb_rsp_t rsp;
  // Handshake toggles
  logic     start_tgl;
  logic     done_tgl;

  ////////////////////////////////////////
  // Debug clock domain
  ////////////////////////////////////////

  dbg_req_port i_req_port (
    .biu_clk       (biu_clk),
    .ahb_rstn      (ahb_rstn),
    .biu_di        (biu_di),
    .biu_addr      (biu_addr),
    .biu_strb      (biu_strb),
    .biu_rw        (biu_rw),
    .biu_word_size (biu_word_size),
    .done_tgl      (done_tgl),
    .biu_rdy       (biu_rdy),
    .req           (req),
    .start_tgl     (start_tgl)
  );

  ////////////////////////////////////////
  // AHB clock domain
  ////////////////////////////////////////

  ahb_xfer_ctrl i_xfer_ctrl (
    .HCLK      (HCLK),
    .ahb_rstn  (ahb_rstn),
    .req       (req),
    .start_tgl (start_tgl),
    .HRDATA    (HRDATA),
    .HREADY    (HREADY),
    .HRESP     (HRESP),
    .HTRANS    (HTRANS),
    .rsp       (rsp),
    .done_tgl  (done_tgl)
  );

  // Address phase straight from the latched request
  assign HADDR  = req.addr;
  assign HWRITE = req.write;
  assign HSIZE  = req.size;
  // Held long enough to cover the data phase as well
  assign HWDATA = req.wdata;

  // Fixed attributes, single unlocked privileged data accesses
  assign HSEL      = 1'b1;
  assign HBURST    = HBURST_SINGLE;
  assign HPROT     = HPROT_DBG;
  assign HMASTLOCK = 1'b0;

  // Response back to the debug side
  assign biu_do  = rsp.rdata;
  assign biu_err = rsp.err;

endmodule

// File: sim/ahb_slave_model.sv
// AHB-Lite memory slave for the bus interface unit testbench
// 256 words indexed by HADDR[9:2], 0 to 3 random wait states per transfer
// Addresses at or above 0x8000_0000 get a two-cycle ERROR response
// Writes touch only the byte lanes selected by HSIZE and the address

module ahb_slave_model (
  input  logic                 hclk,
  input  logic                 ahb_rstn,
  input  logic                 hsel,
  input  dbg_biu_pkg::addr_t   haddr,
  input  logic                 hwrite,
  input  dbg_biu_pkg::hsize_t  hsize,
  input  dbg_biu_pkg::htrans_t htrans,
  input  dbg_biu_pkg::data_t   hwdata,
  output dbg_biu_pkg::data_t   hrdata,
  output logic                 hready,
  output logic                 hresp
);

  timeunit 1ns;
  timeprecision 100ps;

  import dbg_biu_pkg::*;

  // Word storage
  data_t      mem [0:255];
  // Captured address phase
  logic       dph;
  logic [7:0] a_idx;
  logic [1:0] a_lsb;
  hsize_t     a_size;
  logic       a_write;
  logic       a_err;
  // Wait states left and first cycle of the error response
  logic [1:0] wait_cnt;
  logic       err_first;
  // Byte lanes of the captured transfer
  logic [3:0] wr_mask;

  // Byte lanes written for a given size and offset
  function automatic logic [3:0] lane_mask(input hsize_t size, input logic [1:0] lsb);
    case (size)
      HSIZE_BYTE:  return 4'b0001 << lsb;
      HSIZE_HWORD: return lsb[1] ? 4'b1100 : 4'b0011;
      default:     return 4'b1111;
    endcase
  endfunction

  // Fill so that every word differs from its neighbours
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h3c00_0000 ^ (i << 2) ^ (i << 18);
    end
  end

  ////////////////////////////////////////
  // Response outputs
  ////////////////////////////////////////

  // Low during wait states and in the first error cycle
  assign hready = ~dph | ((wait_cnt == 2'd0) & ~(a_err & err_first));
  assign hresp  = dph & a_err & (wait_cnt == 2'd0);
  assign hrdata = (dph & ~a_write) ? mem[a_idx] : '0;

  assign wr_mask = lane_mask(a_size, a_lsb);

  ////////////////////////////////////////
  // Transfer tracking
  ////////////////////////////////////////

  always_ff @(posedge hclk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dph       <= 1'b0;
      a_idx     <= '0;
      a_lsb     <= '0;
      a_size    <= HSIZE_WORD;
      a_write   <= 1'b0;
      a_err     <= 1'b0;
      wait_cnt  <= '0;
      err_first <= 1'b0;
    end else begin
      // Data phase progress
      if (dph) begin
        if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else if (a_err & err_first) begin
          err_first <= 1'b0;
        end else begin
          dph <= 1'b0;
        end
      end
      // New address phase overrides the completion above
      if (hsel && hready && htrans == HTRANS_NONSEQ) begin
        dph       <= 1'b1;
        a_idx     <= haddr[9:2];
        a_lsb     <= haddr[1:0];
        a_size    <= hsize;
        a_write   <= hwrite;
        a_err     <= haddr[31];
        wait_cnt  <= 2'($urandom % 4);
        err_first <= 1'b1;
      end
    end
  end

  // Memory update on the last data phase cycle unless the transfer errors
  always @(posedge hclk) begin
    if (dph && hready && a_write && !a_err) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_mask[b]) begin
          mem[a_idx][8*b +: 8] <= hwdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: sim/tb_dbg_ahb_biu.sv
// Testbench for the debug to AHB-Lite bus interface unit
// Runs directed tests through the debug port against an AHB memory slave
// with random wait states, checks the debug-side results and the
// address phase seen on the bus, and stops on an HCLK cycle watchdog

module tb_dbg_ahb_biu;

  timeunit 1ns;
  timeprecision 100ps;

  import dbg_biu_pkg::*;

  // Watchdog budget of about 40 accesses at most 60 HCLK cycles each
  localparam int MAX_ACCESSES      = 40;
  localparam int MAX_ACCESS_CYCLES = 60;
  // Extra room for reset and idle gaps
  localparam int TIMEOUT_CYCLES    = MAX_ACCESSES * MAX_ACCESS_CYCLES + 1600;

  logic       hclk = 1'b0;
  logic       biu_clk = 1'b0;
  logic       ahb_rstn;
  // Debug side
  data_t      biu_di;
  data_t      biu_do;
  addr_t      biu_addr;
  logic       biu_strb;
  logic       biu_rw;
  logic       biu_rdy;
  logic       biu_err;
  word_size_t biu_word_size;
  // AHB side
  logic       hsel;
  addr_t      haddr;
  data_t      hwdata;
  data_t      hrdata;
  logic       hwrite;
  hsize_t     hsize;
  logic [2:0] hburst;
  logic [3:0] hprot;
  htrans_t    htrans;
  logic       hmastlock;
  logic       hready;
  logic       hresp;

  // Bookkeeping
  int         err_count = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         cycle_cnt = 0;
  int         nonseq_cnt = 0;
  // Last address phase seen on the bus
  addr_t      ap_addr;
  data_t      ap_wdata;
  logic       ap_write;
  hsize_t     ap_size;

  ////////////////////////////////////////
  // Clocks, DUT and slave
  ////////////////////////////////////////

  always #20 hclk = ~hclk;
  always #34 biu_clk = ~biu_clk;

  dbg_ahb_biu i_dut (
    .biu_clk       (biu_clk),
    .biu_di        (biu_di),
    .biu_do        (biu_do),
    .biu_addr      (biu_addr),
    .biu_strb      (biu_strb),
    .biu_rw        (biu_rw),
    .biu_rdy       (biu_rdy),
    .biu_err       (biu_err),
    .biu_word_size (biu_word_size),
    .HCLK          (hclk),
    .ahb_rstn      (ahb_rstn),
    .HSEL          (hsel),
    .HADDR         (haddr),
    .HWDATA        (hwdata),
    .HRDATA        (hrdata),
    .HWRITE        (hwrite),
    .HSIZE         (hsize),
    .HBURST        (hburst),
    .HPROT         (hprot),
    .HTRANS        (htrans),
    .HMASTLOCK     (hmastlock),
    .HREADY        (hready),
    .HRESP         (hresp)
  );

  ahb_slave_model i_slave (
    .hclk     (hclk),
    .ahb_rstn (ahb_rstn),
    .hsel     (hsel),
    .haddr    (haddr),
    .hwrite   (hwrite),
    .hsize    (hsize),
    .htrans   (htrans),
    .hwdata   (hwdata),
    .hrdata   (hrdata),
    .hready   (hready),
    .hresp    (hresp)
  );

  // Address phase monitor that counts every NONSEQ cycle
  always @(posedge hclk) begin
    if (htrans == HTRANS_NONSEQ) begin
      nonseq_cnt++;
      ap_addr  = haddr;
      ap_wdata = hwdata;
      ap_write = hwrite;
      ap_size  = hsize;
    end
  end

  // Watchdog
  always @(posedge hclk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d HCLK cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic compare_word(input string what, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  // One-cycle strobe that the DUT accepts at the second biu_clk edge
  task automatic start_access(input logic rw, input addr_t addr, input data_t di,
                              input word_size_t ws);
    @(posedge biu_clk);
    biu_addr      <= addr;
    biu_di        <= di;
    biu_rw        <= rw;
    biu_word_size <= ws;
    biu_strb      <= 1'b1;
    @(posedge biu_clk);
    biu_strb <= 1'b0;
    @(negedge biu_clk);
    assert (!biu_rdy) else begin
      $display("FAILED at %0t: biu_rdy still high after an accepted strobe", $time);
      err_count++;
    end
  endtask

  // Waits for biu_rdy to rise again
  task automatic finish_access(output data_t rdata, output logic err);
    do begin
      @(negedge biu_clk);
    end while (!biu_rdy);
    rdata = biu_do;
    err   = biu_err;
  endtask

  task automatic run_access(input logic rw, input addr_t addr, input data_t di,
                            input word_size_t ws, output data_t rdata, output logic err);
    start_access(rw, addr, di, ws);
    finish_access(rdata, err);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_values();
    int errs_before;
    errs_before = err_count;
    compare_word("biu_rdy after reset", 32'(biu_rdy), 32'd1);
    compare_word("biu_err after reset", 32'(biu_err), 32'd0);
    compare_word("HTRANS after reset", 32'(htrans), 32'(HTRANS_IDLE));
    // Always selected, single unlocked privileged data transfers
    compare_word("HSEL", 32'(hsel), 32'd1);
    compare_word("HBURST", 32'(hburst), 32'd0);
    compare_word("HPROT", 32'(hprot), 32'h3);
    compare_word("HMASTLOCK", 32'(hmastlock), 32'd0);
    report_test("reset", errs_before);
  endtask

  task automatic word_access();
    int    errs_before;
    data_t di;
    data_t rd;
    logic  err;
    errs_before = err_count;
    di = $urandom;
    // biu_rw low is a write
    run_access(1'b0, 32'h0000_0040, di, 4'd4, rd, err);
    compare_word("word write HWRITE", 32'(ap_write), 32'd1);
    compare_word("word write HSIZE", 32'(ap_size), 32'(HSIZE_WORD));
    compare_word("word write HWDATA", ap_wdata, di);
    compare_word("word write HADDR", ap_addr, 32'h0000_0040);
    compare_word("word write biu_err", 32'(err), 32'd0);
    run_access(1'b1, 32'h0000_0040, '0, 4'd4, rd, err);
    compare_word("word read HWRITE", 32'(ap_write), 32'd0);
    compare_word("word read biu_do", rd, di);
    compare_word("word read biu_err", 32'(err), 32'd0);
    report_test("word_access", errs_before);
  endtask

  task automatic byte_access();
    int    errs_before;
    data_t di;
    data_t rd;
    data_t exp_word;
    logic  err;
    errs_before = err_count;
    exp_word = '0;
    // Only the top byte of the left-justified data counts
    for (int off = 0; off < 4; off++) begin
      di = $urandom;
      run_access(1'b0, 32'h0000_0080 + off, di, 4'd1, rd, err);
      compare_word("byte write HWDATA", ap_wdata, {4{di[31:24]}});
      compare_word("byte write HSIZE", 32'(ap_size), 32'(HSIZE_BYTE));
      exp_word[8*off +: 8] = di[31:24];
    end
    // Little endian puts offset 0 in bits 7:0
    run_access(1'b1, 32'h0000_0080, '0, 4'd4, rd, err);
    compare_word("byte lanes word read", rd, exp_word);
    for (int off = 0; off < 4; off++) begin
      run_access(1'b1, 32'h0000_0080 + off, '0, 4'd1, rd, err);
      compare_word("byte read", rd, {24'h0, exp_word[8*off +: 8]});
    end
    report_test("byte_access", errs_before);
  endtask

  task automatic halfword_access();
    int    errs_before;
    data_t di;
    data_t rd;
    data_t exp_word;
    logic  err;
    errs_before = err_count;
    exp_word = '0;
    for (int off = 0; off < 4; off += 2) begin
      di = $urandom;
      run_access(1'b0, 32'h0000_00c0 + off, di, 4'd2, rd, err);
      compare_word("halfword write HWDATA", ap_wdata, {2{di[31:16]}});
      compare_word("halfword write HSIZE", 32'(ap_size), 32'(HSIZE_HWORD));
      exp_word[8*off +: 16] = di[31:16];
    end
    run_access(1'b1, 32'h0000_00c0, '0, 4'd4, rd, err);
    compare_word("halfword lanes word read", rd, exp_word);
    for (int off = 0; off < 4; off += 2) begin
      run_access(1'b1, 32'h0000_00c0 + off, '0, 4'd2, rd, err);
      compare_word("halfword read", rd, {16'h0, exp_word[8*off +: 16]});
    end
    report_test("halfword_access", errs_before);
  endtask

  task automatic error_response();
    int    errs_before;
    data_t di;
    data_t rd;
    logic  err;
    errs_before = err_count;
    di = $urandom;
    run_access(1'b0, 32'h0000_0100, di, 4'd4, rd, err);
    run_access(1'b1, 32'h8000_0100, '0, 4'd4, rd, err);
    compare_word("error region read biu_err", 32'(err), 32'd1);
    // Aliases word 0x100 in the slave and must not land there
    run_access(1'b0, 32'h8000_0100, ~di, 4'd4, rd, err);
    compare_word("error region write biu_err", 32'(err), 32'd1);
    run_access(1'b1, 32'h0000_0100, '0, 4'd4, rd, err);
    compare_word("read after error biu_err", 32'(err), 32'd0);
    compare_word("read after error biu_do", rd, di);
    report_test("error_response", errs_before);
  endtask

  task automatic ignored_strobe();
    int    errs_before;
    int    nonseq_before;
    data_t keep;
    data_t other;
    data_t rd;
    logic  err;
    errs_before = err_count;
    keep  = $urandom;
    other = $urandom;
    run_access(1'b0, 32'h0000_0200, keep, 4'd4, rd, err);
    run_access(1'b0, 32'h0000_0204, other, 4'd4, rd, err);
    nonseq_before = nonseq_cnt;
    start_access(1'b1, 32'h0000_0204, '0, 4'd4);
    // Second strobe while busy is a write that must be dropped
    @(posedge biu_clk);
    biu_addr      <= 32'h0000_0200;
    biu_di        <= ~keep;
    biu_rw        <= 1'b0;
    biu_word_size <= 4'd4;
    biu_strb      <= 1'b1;
    @(posedge biu_clk);
    biu_strb <= 1'b0;
    finish_access(rd, err);
    compare_word("read under ignored strobe", rd, other);
    run_access(1'b1, 32'h0000_0200, '0, 4'd4, rd, err);
    compare_word("word after ignored strobe", rd, keep);
    compare_word("NONSEQ count", 32'(nonseq_cnt - nonseq_before), 32'd2);
    report_test("ignored_strobe", errs_before);
  endtask

  task automatic random_traffic();
    int    errs_before;
    int    idx;
    addr_t addr_list [8];
    data_t data_list [8];
    bit    used [256];
    data_t r;
    data_t rd;
    logic  err;
    errs_before = err_count;
    // Distinct words with random upper address bits below the error region
    for (int i = 0; i < 8; i++) begin
      do begin
        idx = $urandom % 256;
      end while (used[idx]);
      used[idx] = 1'b1;
      r = $urandom;
      addr_list[i] = {1'b0, r[30:10], idx[7:0], 2'b00};
      data_list[i] = $urandom;
      run_access(1'b0, addr_list[i], data_list[i], 4'd4, rd, err);
    end
    for (int i = 0; i < 8; i++) begin
      run_access(1'b1, addr_list[i], '0, 4'd4, rd, err);
      compare_word("random read back", rd, data_list[i]);
      compare_word("random read biu_err", 32'(err), 32'd0);
    end
    report_test("random_traffic", errs_before);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(15));
    ahb_rstn      = 1'b0;
    biu_di        = '0;
    biu_addr      = '0;
    biu_strb      = 1'b0;
    biu_rw        = 1'b1;
    biu_word_size = 4'd4;
    // Release at 330 ns clear of both clock edges
    repeat (8) @(posedge hclk);
    #30;
    ahb_rstn = 1'b1;
    @(negedge biu_clk);
    reset_values();
    word_access();
    byte_access();
    halfword_access();
    error_response();
    ignored_strobe();
    random_traffic();
    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: sources.f
hdl/dbg_biu_pkg.sv
hdl/ahb_rdata_align.sv
hdl/dbg_req_port.sv
hdl/ahb_xfer_ctrl.sv
hdl/dbg_ahb_biu.sv
sim/ahb_slave_model.sv
sim/tb_dbg_ahb_biu.sv

// File: Bender.yml
package:
  name: dbg_ahb_biu

sources:
  # Package first, then the RTL from the leaves up
  - hdl/dbg_biu_pkg.sv
  - hdl/ahb_rdata_align.sv
  - hdl/dbg_req_port.sv
  - hdl/ahb_xfer_ctrl.sv
  - hdl/dbg_ahb_biu.sv

  # Testbench and slave model
  - target: simulation
    files:
      - sim/ahb_slave_model.sv
      - sim/tb_dbg_ahb_biu.sv
